//--- Bender.yml
package:
  name: tqv_peripherals

sources:
  - periph_pkg.sv
  - periph_addr_decode.sv
  - periph_read_buffer.sv
  - gpio_ctrl.sv
  - pin_out_mux.sv
  - periph_reg_bank.sv
  - tqv_peripherals.sv
  - target: test
    files:
      - tb_tqv_peripherals_sva.sv
      - tb_tqv_peripherals.sv

//--- gpio_ctrl.sv
// GPIO block: output register, input readback and one function select per output pin
// Only the low bits of a write are kept, whatever the write size
// Offsets that match no register read as zero, writes to them are dropped
// Always ready, reads are answered in the same cycle
`timescale 1ns/1ps

module gpio_ctrl
    import periph_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_sel,
    input  logic [USER_OFS_W-1:0]         i_addr,
    input  word_t                         i_data,
    input  logic [1:0]                    i_data_write_n,
    input  logic [PIN_W-1:0]              i_ui_in,
    output word_t                         o_rdata,
    output logic [PIN_W-1:0]              o_uo_out,
    output logic [PIN_W-1:0][FSEL_W-1:0]  o_fsel
);

    logic [PIN_W-1:0]             gpio_out;
    logic [PIN_W-1:0][FSEL_W-1:0] fsel;
    logic [PIN_W-1:0]             fsel_hit;    // Offset matches the select word of pin n
    logic                         wr_en;

    assign wr_en = i_sel && (i_data_write_n != SIZE_NONE);

    always_comb begin
        for (int n = 0; n < PIN_W; n++) begin
            fsel_hit[n] = (i_addr == GPIO_FSEL_BASE + USER_OFS_W'(4 * n));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            fsel     <= {PIN_W{FSEL_RESET}};   // Every pin driven by GPIO
        end else if (wr_en) begin
            if (i_addr == GPIO_OUT_OFS) begin
                gpio_out <= i_data[PIN_W-1:0];
            end
            for (int n = 0; n < PIN_W; n++) begin
                if (fsel_hit[n]) begin
                    fsel[n] <= i_data[FSEL_W-1:0];
                end
            end
        end
    end

    // Read side
    always_comb begin
        o_rdata = '0;
        if (i_addr == GPIO_OUT_OFS) begin
            o_rdata = word_t'(gpio_out);
        end else if (i_addr == GPIO_IN_OFS) begin
            o_rdata = word_t'(i_ui_in);
        end
        for (int n = 0; n < PIN_W; n++) begin
            if (fsel_hit[n]) begin
                o_rdata = word_t'(fsel[n]);
            end
        end
    end

    assign o_uo_out = gpio_out;
    assign o_fsel   = fsel;

endmodule

//--- periph_addr_decode.sv
// Slot select and read return multiplexer, purely combinational
// Slot indices past the populated range select nothing and read as zero with ready high
// Simple slots are always ready and their byte is zero-extended
`timescale 1ns/1ps

module periph_addr_decode
    import periph_pkg::*;
(
    input  logic [ADDR_W-1:0]                i_addr,
    input  word_t [NUM_USER-1:0]             i_slot_rdata_user,
    input  logic [NUM_USER-1:0]              i_slot_ready_user,
    input  byte_t [NUM_SIMPLE-1:0]           i_slot_rdata_simple,
    output logic [NUM_USER-1:0]              o_sel_user,
    output logic [NUM_SIMPLE-1:0]            o_sel_simple,
    output word_t                            o_rdata,
    output logic                             o_rready
);

    logic                    simple_region;
    logic [USER_IDX_W-1:0]   user_idx;
    logic [SIMPLE_IDX_W-1:0] simple_idx;

    assign simple_region = i_addr[SIMPLE_SEL_BIT];
    assign user_idx      = i_addr[USER_IDX_LO +: USER_IDX_W];
    assign simple_idx    = i_addr[SIMPLE_IDX_LO +: SIMPLE_IDX_W];

    always_comb begin
        o_sel_user   = '0;
        o_sel_simple = '0;
        o_rdata      = '0;      // Empty slot answer
        o_rready     = 1'b1;

        for (int u = 0; u < NUM_USER; u++) begin
            if (!simple_region && user_idx == USER_IDX_W'(u)) begin
                o_sel_user[u] = 1'b1;
                o_rdata       = i_slot_rdata_user[u];
                o_rready      = i_slot_ready_user[u];
            end
        end

        for (int s = 0; s < NUM_SIMPLE; s++) begin
            if (simple_region && simple_idx == SIMPLE_IDX_W'(s)) begin
                o_sel_simple[s] = 1'b1;
                o_rdata         = word_t'(i_slot_rdata_simple[s]);
            end
        end
    end

endmodule

//--- periph_pkg.sv
// Shared constants and types for the peripheral bus wrapper
// Address fields keep the full-size map even though only 4 slots of each kind exist
// Size codes follow the core's read and write strobes, 2'b11 means idle
package periph_pkg;

    // Bus and pin widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int PIN_W  = 8;

    // Populated slots
    localparam int NUM_USER   = 4;
    localparam int NUM_SIMPLE = 4;

    // Address map fields
    localparam int SIMPLE_SEL_BIT = 10;   // Set for the simple region
    localparam int USER_IDX_LO    = 6;    // User index in bits 9:6
    localparam int USER_IDX_W     = 4;
    localparam int SIMPLE_IDX_LO  = 4;    // Simple index in bits 7:4
    localparam int SIMPLE_IDX_W   = 4;
    localparam int USER_OFS_W     = 6;    // 64 bytes per user slot
    localparam int SIMPLE_OFS_W   = 4;    // 16 bytes per simple slot

    // Access size codes
    localparam logic [1:0] SIZE_NONE = 2'b11;
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // Slot numbers
    localparam int SLOT_GPIO   = 1;
    localparam int SLOT_REGS   = 2;
    localparam int SIMPLE_REGS = 0;

    // GPIO register offsets, one select word per pin from the base
    localparam logic [USER_OFS_W-1:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [USER_OFS_W-1:0] GPIO_IN_OFS    = 6'h04;
    localparam logic [USER_OFS_W-1:0] GPIO_FSEL_BASE = 6'h20;

    // Function select, bit 4 picks the simple region, bits 3:0 the slot
    localparam int               FSEL_W     = 5;
    localparam logic [FSEL_W-1:0] FSEL_RESET = 5'(SLOT_GPIO);

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [7:0]        byte_t;

endpackage

//--- periph_read_buffer.sv
// Registered read return toward the core
// Data is captured the edge after the slot answers ready and held until read complete
// A read that finds the buffer still full waits until the core completes the previous one
// Write acknowledge is combinational, so a write finishes in the cycle it is presented
`timescale 1ns/1ps

module periph_read_buffer
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] i_data_read_n,
    input  logic [1:0] i_data_write_n,
    input  word_t      i_rdata,
    input  logic       i_rready,
    input  logic       i_data_read_complete,
    output word_t      o_data_out,
    output logic       o_data_ready,
    output logic [1:0] o_read_n_masked
);

    logic  hold;        // Buffer holds data the core has not completed
    logic  ready_q;
    logic  read_req;
    logic  capture;
    word_t data_q;

    // Core keeps its read size up during the ready cycle, so hide it from the slots
    assign o_read_n_masked = i_data_read_n | {2{ready_q}};
    assign read_req        = o_read_n_masked != SIZE_NONE;
    assign capture         = read_req && i_rready && (!hold || i_data_read_complete);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= capture;     // One cycle pulse, masked request drops it
            if (capture) begin
                hold <= 1'b1;
            end else if (i_data_read_complete) begin
                hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rdata;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_data_write_n != SIZE_NONE);

endmodule

//--- periph_reg_bank.sv
// Four-register example peripheral, word wide in a user slot or byte wide in a simple slot
// Registers sit at word offsets for word_t and byte offsets for byte_t
// Writes keep the bottom 8, 16 or 32 bits, zero-extended, then cut to the register width
// Offsets past the fourth register read zero and ignore writes
`timescale 1ns/1ps

module periph_reg_bank
    import periph_pkg::*;
#(
    parameter type data_t = word_t,
    localparam int OFS_W   = ($bits(data_t) == DATA_W) ? USER_OFS_W : SIMPLE_OFS_W,
    localparam int REG_LSB = $clog2($bits(data_t) / 8)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_sel,
    input  logic [OFS_W-1:0] i_addr,
    input  data_t            i_data,
    input  logic [1:0]       i_write,
    output data_t            o_rdata,
    output logic [PIN_W-1:0] o_uo_out
);

    data_t      regs [4];
    logic [1:0] reg_idx;
    logic       reg_hit;
    word_t      size_mask;
    data_t      wdata;

    assign reg_idx = i_addr[REG_LSB +: 2];
    assign reg_hit = i_addr[OFS_W-1:REG_LSB+2] == '0;

    always_comb begin
        case (i_write)
            SIZE_BYTE: size_mask = 32'h0000_00ff;
            SIZE_HALF: size_mask = 32'h0000_ffff;
            default:   size_mask = '1;
        endcase
    end

    assign wdata = data_t'(word_t'(i_data) & size_mask);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 4; r++) begin
                regs[r] <= '0;
            end
        end else if (i_sel && i_write != SIZE_NONE && reg_hit) begin
            regs[reg_idx] <= wdata;
        end
    end

    assign o_rdata  = reg_hit ? regs[reg_idx] : '0;
    assign o_uo_out = regs[0][PIN_W-1:0];       // Pin word for the output router

endmodule

//--- pin_out_mux.sv
// Output pin routing, combinational
// Pin n takes bit n of the pin word of the slot its select names
// A select naming a slot past the populated range drives the pin low
`timescale 1ns/1ps

module pin_out_mux
    import periph_pkg::*;
(
    input  logic [PIN_W-1:0][FSEL_W-1:0]     i_fsel,
    input  logic [NUM_USER-1:0][PIN_W-1:0]   i_user_pins,
    input  logic [NUM_SIMPLE-1:0][PIN_W-1:0] i_simple_pins,
    output logic [PIN_W-1:0]                 o_uo_out
);

    always_comb begin
        o_uo_out = '0;
        for (int n = 0; n < PIN_W; n++) begin
            for (int u = 0; u < NUM_USER; u++) begin
                if (!i_fsel[n][FSEL_W-1] && i_fsel[n][FSEL_W-2:0] == (FSEL_W-1)'(u)) begin
                    o_uo_out[n] = i_user_pins[u][n];
                end
            end
            for (int s = 0; s < NUM_SIMPLE; s++) begin
                if (i_fsel[n][FSEL_W-1] && i_fsel[n][FSEL_W-2:0] == (FSEL_W-1)'(s)) begin
                    o_uo_out[n] = i_simple_pins[s][n];    // Simple region
                end
            end
        end
    end

endmodule

//--- sources.f
periph_pkg.sv
periph_addr_decode.sv
periph_read_buffer.sv
gpio_ctrl.sv
pin_out_mux.sv
periph_reg_bank.sv
tqv_peripherals.sv
tb_tqv_peripherals_sva.sv
tb_tqv_peripherals.sv

//--- tb_tqv_peripherals.sv
// Directed testbench for the peripheral bus wrapper
// Inputs change on the falling clock edge and outputs are sampled there as well
// Every populated slot answers at once, so each read must finish in one cycle
`timescale 1ns/1ps

module tb_tqv_peripherals
    import periph_pkg::*;
();

    localparam int MAX_CYCLES = 2000;   // Far above the length of all tests
    localparam int READ_WAIT  = 16;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [PIN_W-1:0]  i_ui_in;
    logic [PIN_W-1:0]  o_uo_out;
    logic [ADDR_W-1:0] i_addr;
    word_t             i_data;
    logic [1:0]        i_data_write_n;
    logic [1:0]        i_data_read_n;
    word_t             o_data_out;
    logic              o_data_ready;
    logic              i_data_read_complete;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [15:0] lfsr_state = 16'd98;

    tqv_peripherals tqv_peripherals_i (.*);

    always #10 clk = ~clk;

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[DATA_W-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Address map: user index in bits 9:6, simple region at bit 10 with index in bits 7:4
    function automatic logic [ADDR_W-1:0] user_addr(input int slot, input int ofs);
        return ADDR_W'((slot << 6) + ofs);
    endfunction

    function automatic logic [ADDR_W-1:0] simple_addr(input int slot, input int ofs);
        return ADDR_W'(1024 + (slot << 4) + ofs);
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] a, input word_t d, input logic [1:0] size);
        @(negedge clk);
        i_addr         = a;
        i_data         = d;
        i_data_write_n = size;
        #5;
        check_value("o_data_ready", word_t'(o_data_ready), 1);   // Write acknowledged at once
        @(negedge clk);
        i_data_write_n = SIZE_NONE;
    endtask

    // Waits for ready, then holds off read complete for hold_cycles
    task automatic bus_read(input logic [ADDR_W-1:0] a, input word_t exp, input int hold_cycles);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        i_addr        = a;
        i_data_read_n = SIZE_WORD;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (!o_data_ready && wait_cnt < READ_WAIT);
        if (!o_data_ready) begin
            errors++;
            $display("Read of address 0x%h saw no data ready within %0d cycles", a, READ_WAIT);
        end
        check_value("read latency", word_t'(wait_cnt), 1);
        check_value("o_data_out", o_data_out, exp);
        // Core keeps its read size up through the ready cycle
        i_data_read_complete = (hold_cycles == 0);
        @(negedge clk);
        i_data_read_n = SIZE_NONE;
        check_value("o_data_ready", word_t'(o_data_ready), 0);
        check_value("o_data_out", o_data_out, exp);
        if (hold_cycles > 0) begin
            repeat (hold_cycles - 1) begin
                @(negedge clk);
                check_value("o_data_ready", word_t'(o_data_ready), 0);
                check_value("o_data_out", o_data_out, exp);
            end
            i_data_read_complete = 1'b1;
            @(negedge clk);
            check_value("o_data_ready", word_t'(o_data_ready), 0);
        end
        i_data_read_complete = 1'b0;
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        @(negedge clk);
        check_value("o_uo_out", word_t'(o_uo_out), 0);
        for (int n = 0; n < PIN_W; n++) begin
            bus_read(user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 4 * n), word_t'(FSEL_RESET), 0);
        end
        $display("test reset_state     done, %0d errors", errors - start);
    endtask

    task automatic test_gpio();
        int    start;
        word_t v;
        word_t pins;
        start = errors;
        v     = random_bits(PIN_W);
        bus_write(user_addr(SLOT_GPIO, GPIO_OUT_OFS), v, SIZE_WORD);
        check_value("o_uo_out", word_t'(o_uo_out), v);
        bus_read(user_addr(SLOT_GPIO, GPIO_OUT_OFS), v, 1);
        pins    = random_bits(PIN_W);
        i_ui_in = pins[PIN_W-1:0];
        bus_read(user_addr(SLOT_GPIO, GPIO_IN_OFS), pins, 0);
        $display("test gpio            done, %0d errors", errors - start);
    endtask

    task automatic test_user_regs();
        int    start;
        word_t d;
        start = errors;
        d     = random_bits(DATA_W);
        bus_write(user_addr(SLOT_REGS, 4), d, SIZE_WORD);
        bus_write(user_addr(SLOT_REGS, 8), d, SIZE_HALF);
        bus_write(user_addr(SLOT_REGS, 12), d, SIZE_BYTE);
        bus_read(user_addr(SLOT_REGS, 4), d, 2);
        bus_read(user_addr(SLOT_REGS, 8), d & 32'h0000_ffff, 0);
        bus_read(user_addr(SLOT_REGS, 12), d & 32'h0000_00ff, 3);
        bus_write(user_addr(SLOT_REGS, 4), ~d, SIZE_BYTE);     // Upper bytes cleared
        bus_read(user_addr(SLOT_REGS, 4), ~d & 32'h0000_00ff, 1);
        $display("test user_regs       done, %0d errors", errors - start);
    endtask

    task automatic test_simple_regs();
        int    start;
        word_t d;
        start = errors;
        for (int r = 0; r < 4; r++) begin
            d = random_bits(DATA_W);
            bus_write(simple_addr(SIMPLE_REGS, r), d, (r % 2) ? SIZE_BYTE : SIZE_WORD);
            bus_read(simple_addr(SIMPLE_REGS, r), d & 32'h0000_00ff, 0);
        end
        // Empty and out of range slots
        bus_read(user_addr(0, 0), 0, 0);
        bus_read(user_addr(3, 4), 0, 0);
        bus_read(user_addr(9, 0), 0, 0);
        bus_read(simple_addr(1, 0), 0, 0);
        bus_read(simple_addr(12, 0), 0, 0);
        $display("test simple_regs     done, %0d errors", errors - start);
    endtask

    task automatic test_pin_routing();
        int                start;
        word_t             pu;
        word_t             ps;
        logic [FSEL_W-1:0] sel;
        start = errors;
        pu    = random_bits(PIN_W);
        ps    = random_bits(PIN_W);
        bus_write(user_addr(SLOT_GPIO, GPIO_OUT_OFS), 32'hff, SIZE_BYTE);
        bus_write(user_addr(SLOT_REGS, 0), pu, SIZE_WORD);
        bus_write(simple_addr(SIMPLE_REGS, 0), ps, SIZE_BYTE);
        for (int n = 0; n < PIN_W; n++) begin
            case (n)
                0, 1, 2: sel = FSEL_W'(SLOT_REGS);
                3, 4, 5: sel = 5'h10 | FSEL_W'(SIMPLE_REGS);
                6:       sel = 5'h03;     // Empty user slot
                default: sel = 5'h15;     // Simple slot past the populated ones
            endcase
            bus_write(user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 4 * n), word_t'(sel), SIZE_WORD);
        end
        check_value("o_uo_out", word_t'(o_uo_out), (pu & 32'h07) | (ps & 32'h38));
        bus_read(user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 12), 32'h10, 0);
        $display("test pin_routing     done, %0d errors", errors - start);
    endtask

    initial begin
        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = SIZE_NONE;
        i_data_read_n        = SIZE_NONE;
        i_data_read_complete = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_gpio();
        test_user_regs();
        test_simple_regs();
        test_pin_routing();

        // Failures of the bound bus timing assertions
        if (tqv_peripherals_i.u_read_buffer.read_buffer_sva.fail_count != 0) begin
            $display("Bus timing assertions failed %0d times",
                     tqv_peripherals_i.u_read_buffer.read_buffer_sva.fail_count);
            errors += tqv_peripherals_i.u_read_buffer.read_buffer_sva.fail_count;
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_tqv_peripherals_sva.sv
// Read handshake checks on the read return buffer, attached by bind
// Only the registered read ready is checked, write acknowledge is combinational
`timescale 1ns/1ps

module tb_tqv_peripherals_sva
    import periph_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  hold,
    input logic  ready_q,
    input logic  i_data_read_complete,
    input word_t i_rdata,
    input word_t o_data_out
);

    int fail_count = 0;

    // Read ready is a single cycle pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ready_q |=> !ready_q)
        else begin
            fail_count++;
            $error("read ready stayed high for more than one cycle");
        end

    a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        hold && !i_data_read_complete |=> $stable(o_data_out))
        else begin
            fail_count++;
            $error("read data changed before read complete");
        end

    // Data shown with read ready is what the slot answered at the capture edge
    a_data_captured: assert property (@(posedge clk) disable iff (!rst_n)
        ready_q |-> o_data_out == $past(i_rdata))
        else begin
            fail_count++;
            $error("read data does not match the slot answer at capture");
        end

endmodule

bind periph_read_buffer tb_tqv_peripherals_sva read_buffer_sva (
    .clk                  (clk),
    .rst_n                (rst_n),
    .hold                 (hold),
    .ready_q              (ready_q),
    .i_data_read_complete (i_data_read_complete),
    .i_rdata              (i_rdata),
    .o_data_out           (o_data_out)
);

//--- tqv_peripherals.sv
// Peripheral bus wrapper for the core's native bus
// User slots 1 (GPIO) and 2 (register bank) and simple slot 0 (register bank) are populated
// All other slots read zero with ready high and drive no pins
// No interrupts, the core must hold a read until o_data_ready
`timescale 1ns/1ps

module tqv_peripherals
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [PIN_W-1:0]  i_ui_in,
    output logic [PIN_W-1:0]  o_uo_out,
    input  logic [ADDR_W-1:0] i_addr,
    input  word_t             i_data,
    input  logic [1:0]        i_data_write_n,
    input  logic [1:0]        i_data_read_n,
    output word_t             o_data_out,
    output logic              o_data_ready,
    input  logic              i_data_read_complete
);

    wire word_t [NUM_USER-1:0]         user_rdata;
    wire logic [NUM_USER-1:0]          user_ready;
    wire logic [NUM_USER-1:0][PIN_W-1:0]   user_pins;
    wire byte_t [NUM_SIMPLE-1:0]       simple_rdata;
    wire logic [NUM_SIMPLE-1:0][PIN_W-1:0] simple_pins;

    logic [NUM_USER-1:0]          sel_user;
    logic [NUM_SIMPLE-1:0]        sel_simple;
    word_t                        slot_rdata;
    logic                         slot_rready;
    logic [PIN_W-1:0][FSEL_W-1:0] fsel;

    periph_addr_decode u_decode (
        .i_addr              (i_addr),
        .i_slot_rdata_user   (user_rdata),
        .i_slot_ready_user   (user_ready),
        .i_slot_rdata_simple (simple_rdata),
        .o_sel_user          (sel_user),
        .o_sel_simple        (sel_simple),
        .o_rdata             (slot_rdata),
        .o_rready            (slot_rready)
    );

    // No populated slot has read side effects, so the masked read size has no load
    periph_read_buffer u_read_buffer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_rdata              (slot_rdata),
        .i_rready             (slot_rready),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_read_n_masked      ()
    );

    gpio_ctrl u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_sel          (sel_user[SLOT_GPIO]),
        .i_addr         (i_addr[USER_OFS_W-1:0]),
        .i_data         (i_data),
        .i_data_write_n (i_data_write_n),
        .i_ui_in        (i_ui_in),
        .o_rdata        (user_rdata[SLOT_GPIO]),
        .o_uo_out       (user_pins[SLOT_GPIO]),
        .o_fsel         (fsel)
    );

    periph_reg_bank #(.data_t(word_t)) u_user_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_sel    (sel_user[SLOT_REGS]),
        .i_addr   (i_addr[USER_OFS_W-1:0]),
        .i_data   (i_data),
        .i_write  (i_data_write_n),
        .o_rdata  (user_rdata[SLOT_REGS]),
        .o_uo_out (user_pins[SLOT_REGS])
    );

    periph_reg_bank #(.data_t(byte_t)) u_simple_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_sel    (sel_simple[SIMPLE_REGS]),
        .i_addr   (i_addr[SIMPLE_OFS_W-1:0]),
        .i_data   (i_data[7:0]),
        .i_write  (i_data_write_n),
        .o_rdata  (simple_rdata[SIMPLE_REGS]),
        .o_uo_out (simple_pins[SIMPLE_REGS])
    );

    // Both populated user slots answer in the same cycle
    assign user_ready[SLOT_GPIO] = 1'b1;
    assign user_ready[SLOT_REGS] = 1'b1;

    for (genvar u = 0; u < NUM_USER; u++) begin : g_user_empty
        if (u != SLOT_GPIO && u != SLOT_REGS) begin : g_tie
            assign user_rdata[u] = '0;
            assign user_ready[u] = 1'b1;
            assign user_pins[u]  = '0;
        end
    end

    for (genvar s = 0; s < NUM_SIMPLE; s++) begin : g_simple_empty
        if (s != SIMPLE_REGS) begin : g_tie
            assign simple_rdata[s] = '0;
            assign simple_pins[s]  = '0;
        end
    end

    pin_out_mux u_pin_mux (
        .i_fsel        (fsel),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_uo_out      (o_uo_out)
    );

endmodule
